/* project.f */
+incdir+.
rv32i_isa_pkg.sv
decoder_pkg.sv
imm_gen.sv
hazard_unit.sv
decode_fsm.sv
instr_decoder_top.sv
tb_instr_decoder.sv

/* run.sh */
#!/bin/sh
# Compile and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_instr_decoder -f project.f -o tb_instr_decoder
./obj_dir/tb_instr_decoder | tee sim.log
if grep -q "^PASS: all tests$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb_vectors.svh */
// Stimulus and expected-value table for the decoder testbench
// Columns are name, instruction, random PC, decode cycles, alu_o, lsu_o, jmp_o, illegal_o
// The jmp_o address column holds the offset from PC
add_vector("add", 32'h003100B3, 1'b0, 1,
  '{1'b1, ALU_ADD, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 32'h0}, '0, '0, 1'b0);
add_vector("sub", 32'h40628233, 1'b0, 1,
  '{1'b1, ALU_SUB, 5'd4, 5'd5, 5'd6, 1'b0, 1'b0, 32'h0}, '0, '0, 1'b0);
add_vector("slti_raw", 32'hFFB22393, 1'b0, 2,  // Reads x4 written just before
  '{1'b1, ALU_SLT, 5'd7, 5'd4, 5'd0, 1'b1, 1'b0, 32'hFFFF_FFFB}, '0, '0, 1'b0);
add_vector("srai_old", 32'h40325413, 1'b0, 1,  // x4 is an older destination
  '{1'b1, ALU_SRA, 5'd8, 5'd4, 5'd0, 1'b1, 1'b0, 32'h3}, '0, '0, 1'b0);
add_vector("addi_x0", 32'h00508013, 1'b0, 1,
  '{1'b1, ALU_ADD, 5'd0, 5'd1, 5'd0, 1'b1, 1'b0, 32'h5}, '0, '0, 1'b0);
add_vector("add_x0", 32'h003005B3, 1'b0, 1,    // Reads x0 right after a write to x0
  '{1'b1, ALU_ADD, 5'd11, 5'd0, 5'd3, 1'b0, 1'b0, 32'h0}, '0, '0, 1'b0);
add_vector("add_rs2_raw", 32'h00B107B3, 1'b0, 2,  // Reads x11 through rs2
  '{1'b1, ALU_ADD, 5'd15, 5'd2, 5'd11, 1'b0, 1'b0, 32'h0}, '0, '0, 1'b0);
add_vector("lui", 32'h12345637, 1'b0, 1,
  '{1'b1, ALU_ADD, 5'd12, 5'd0, 5'd0, 1'b1, 1'b0, 32'h1234_5000}, '0, '0, 1'b0);
add_vector("auipc", 32'hFFFFF697, 1'b1, 1,
  '{1'b1, ALU_ADD, 5'd13, 5'd0, 5'd0, 1'b1, 1'b1, 32'hFFFF_F000}, '0, '0, 1'b0);
add_vector("lw_raw", 32'hFF86A703, 1'b1, 3,    // Stall, address, issue
  '{1'b0, ALU_ADD, 5'd0, 5'd13, 5'd0, 1'b1, 1'b0, 32'hFFFF_FFF8},
  '{1'b1, 1'b0, 3'b010, 5'd14}, '0, 1'b0);
add_vector("sw", 32'hFE532A23, 1'b0, 2,
  '{1'b0, ALU_ADD, 5'd0, 5'd6, 5'd5, 1'b1, 1'b0, 32'hFFFF_FFF4},
  '{1'b1, 1'b1, 3'b010, 5'd0}, '0, 1'b0);
add_vector("addi_after_sw", 32'h001A0813, 1'b0, 1,  // Store rd field x20 is no destination
  '{1'b1, ALU_ADD, 5'd16, 5'd20, 5'd0, 1'b1, 1'b0, 32'h1}, '0, '0, 1'b0);
add_vector("jal", 32'hFF1FF0EF, 1'b1, 1,
  '{1'b1, ALU_ADD, 5'd1, 5'd0, 5'd0, 1'b1, 1'b1, `DATA_WIDTH'(`LINK_OFFSET)},
  '0, '{1'b1, 32'hFFFF_FFF0}, 1'b0);
add_vector("beq", 32'h00208463, 1'b0, 1, '0, '0, '0, 1'b1);
add_vector("jalr", 32'h000100E7, 1'b0, 1, '0, '0, '0, 1'b1);
add_vector("ecall", 32'h00000073, 1'b0, 1, '0, '0, '0, 1'b1);
add_vector("fence", 32'h0FF0000F, 1'b0, 1, '0, '0, '0, 1'b0);  // No outputs at all

/* tb_instr_decoder.sv */
// Decoder testbench with clock, reset, table-driven stimulus, output checks and watchdog
`include "decoder_macros.svh"

module tb_instr_decoder;
  import decoder_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;

  typedef struct {
    string                  name;
    logic [`DATA_WIDTH-1:0] instr;
    logic                   rand_pc;
    int                     cycles;   // Decode cycles including a stall
    alu_ctrl_t              alu;      // After the first decode cycle
    lsu_ctrl_t              lsu;      // After the last decode cycle
    jmp_t                   jmp;      // addr is the offset from PC
    logic                   illegal;
  } vector_t;

  logic                   clk_i = 1'b0;
  logic                   rstn_i;
  logic [`DATA_WIDTH-1:0] instr_i;
  logic [`DATA_WIDTH-1:0] pc_i;
  logic                   instr_valid_i;
  logic                   ready_o;
  alu_ctrl_t              alu_o;
  lsu_ctrl_t              lsu_o;
  jmp_t                   jmp_o;
  logic                   illegal_o;

  vector_t vectors[$];
  integer  seed = 7638;

  instr_decoder_top i_instr_decoder_top (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .ready_o       (ready_o),
    .alu_o         (alu_o),
    .lsu_o         (lsu_o),
    .jmp_o         (jmp_o),
    .illegal_o     (illegal_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Table and checks
  ////////////////////////////////////////////////////////////

  task automatic add_vector(input string name, input logic [`DATA_WIDTH-1:0] instr,
                            input logic rand_pc, input int cycles, input alu_ctrl_t alu,
                            input lsu_ctrl_t lsu, input jmp_t jmp, input logic illegal);
    vector_t v;
    v.name    = name;
    v.instr   = instr;
    v.rand_pc = rand_pc;
    v.cycles  = cycles;
    v.alu     = alu;
    v.lsu     = lsu;
    v.jmp     = jmp;
    v.illegal = illegal;
    vectors.push_back(v);
  endtask

  task automatic load_vectors();
    `include "tb_vectors.svh"
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // One entry from the first valid cycle to the consuming edge
  task automatic apply_vector(input vector_t v, input int idx);
    logic [`DATA_WIDTH-1:0] pc;
    jmp_t                   exp_jmp;
    int                     stalls;
    int                     cycle;
    logic                   consumed;
    pc = v.rand_pc ? ($random(seed) & 32'hFFFF_FFFC) : (32'h1000 + 32'(4 * idx));
    exp_jmp = '0;
    if (v.jmp.valid) begin
      exp_jmp.valid = 1'b1;
      exp_jmp.addr  = pc + v.jmp.addr;  // Target from the J offset
    end
    stalls = v.cycles - (v.lsu.valid ? 2 : 1);  // Address plus issue for memory ops
    instr_i       = v.instr;
    pc_i          = pc;
    instr_valid_i = 1'b1;
    cycle    = 0;
    consumed = 1'b0;
    while (!consumed) begin
      #(CLK_PERIOD / 4);
      compare_value({v.name, " ready"}, 64'(cycle == v.cycles - 1), 64'(ready_o));
      consumed = ready_o;
      @(negedge clk_i);  // Registered outputs of the edge just passed
      if (cycle == stalls) begin
        compare_value({v.name, " alu"}, 64'(v.alu), 64'(alu_o));
        compare_value({v.name, " jmp"}, 64'(exp_jmp), 64'(jmp_o));
        compare_value({v.name, " illegal"}, 64'(v.illegal), 64'(illegal_o));
      end else begin
        compare_value({v.name, " alu idle"}, 64'h0, 64'(alu_o));
        compare_value({v.name, " jmp idle"}, 64'h0, 64'(jmp_o));
        compare_value({v.name, " illegal idle"}, 64'h0, 64'(illegal_o));
      end
      if (cycle == v.cycles - 1) begin
        compare_value({v.name, " lsu"}, 64'(v.lsu), 64'(lsu_o));
      end else begin
        compare_value({v.name, " lsu idle"}, 64'h0, 64'(lsu_o));
      end
      cycle++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    rstn_i        = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    instr_valid_i = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rstn_i = 1'b1;
    #(CLK_PERIOD / 4);
    compare_value("reset ready", 64'h1, 64'(ready_o));
    compare_value("reset outputs", 64'h0,
                  64'({alu_o.wb, lsu_o.valid, jmp_o.valid, illegal_o}));
    @(negedge clk_i);
    foreach (vectors[i]) begin
      apply_vector(vectors[i], i);
    end
    instr_valid_i = 1'b0;
    $display("PASS: all tests");
    $finish;
  end

  initial begin : watchdog
    int limit_cycles;
    #1;
    limit_cycles = (vectors.size() * 4 + RESET_CYCLES) * 2;
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: the decoder did not finish the tests within %0d cycles", limit_cycles);
    $display("FAIL: see errors above");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* instr_decoder_top.sv */
// Decoder top level with field split, immediate generator, hazard unit and sequencer
`include "decoder_macros.svh"

module instr_decoder_top (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic [`DATA_WIDTH-1:0] instr_i,
  input  logic [`DATA_WIDTH-1:0] pc_i,
  input  logic                   instr_valid_i,
  output logic                   ready_o,
  output decoder_pkg::alu_ctrl_t alu_o,
  output decoder_pkg::lsu_ctrl_t lsu_o,
  output decoder_pkg::jmp_t      jmp_o,
  output logic                   illegal_o
);
  import rv32i_isa_pkg::*;

  instr_fields_t              fields;
  logic [`DATA_WIDTH-1:0]     imm;
  logic                       hazard;
  logic                       issue;
  logic                       issue_wb;
  logic [`REG_ADDR_WIDTH-1:0] issue_dest;

  assign fields = instr_fields_t'(instr_i);  // Field split

  imm_gen i_imm_gen (
    .fields_i (fields),
    .imm_o    (imm)
  );

  hazard_unit i_hazard_unit (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .fields_i     (fields),
    .issue_i      (issue),
    .issue_wb_i   (issue_wb),
    .issue_dest_i (issue_dest),
    .hazard_o     (hazard)
  );

  decode_fsm i_decode_fsm (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .fields_i      (fields),
    .pc_i          (pc_i),
    .instr_valid_i (instr_valid_i),
    .imm_i         (imm),
    .hazard_i      (hazard),
    .ready_o       (ready_o),
    .issue_o       (issue),
    .issue_wb_o    (issue_wb),
    .issue_dest_o  (issue_dest),
    .alu_o         (alu_o),
    .lsu_o         (lsu_o),
    .jmp_o         (jmp_o),
    .illegal_o     (illegal_o)
  );

endmodule

/* decode_fsm.sv */
// Decode sequencer FSM with stall, load/store sequencing, JAL target adder and output registers
`include "decoder_macros.svh"

module decode_fsm (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  rv32i_isa_pkg::instr_fields_t fields_i,
  input  logic [`DATA_WIDTH-1:0]       pc_i,
  input  logic                         instr_valid_i,
  input  logic [`DATA_WIDTH-1:0]       imm_i,
  input  logic                         hazard_i,
  output logic                         ready_o,
  output logic                         issue_o,
  output logic                         issue_wb_o,
  output logic [`REG_ADDR_WIDTH-1:0]   issue_dest_o,
  output decoder_pkg::alu_ctrl_t       alu_o,
  output decoder_pkg::lsu_ctrl_t       lsu_o,
  output decoder_pkg::jmp_t            jmp_o,
  output logic                         illegal_o
);
  import rv32i_isa_pkg::*;
  import decoder_pkg::*;

  // Each state names what the previous cycle decided
  typedef enum logic [1:0] {
    IDLE,
    STALL,
    LSU_ADDR,
    LSU_ISSUE
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  alu_ctrl_t              alu_d;
  lsu_ctrl_t              lsu_d;
  jmp_t                   jmp_d;
  logic                   illegal_d;
  logic                   is_mem;
  logic                   is_store;
  logic                   is_shift;
  logic                   stall_req;
  logic [`DATA_WIDTH-1:0] jmp_target;

  assign is_store = (fields_i.opcode == OPCODE_STORE);
  assign is_mem   = is_store || (fields_i.opcode == OPCODE_LOAD);
  assign is_shift = (fields_i.funct3 == `FUNCT3_SHIFT_LEFT) ||
                    (fields_i.funct3 == `FUNCT3_SHIFT_RIGHT);

  // Second cycle of a load/store and the cycle after a stall skip the hazard
  assign stall_req = instr_valid_i && hazard_i && (state_q != STALL) && (state_q != LSU_ADDR);

  assign jmp_target = pc_i + imm_i;  // Dedicated JAL adder

  ////////////////////////////////////////////////////////////
  // Fetch handshake and hazard tracking
  ////////////////////////////////////////////////////////////

  assign ready_o = (state_q == LSU_ADDR) || !(stall_req || (instr_valid_i && is_mem));
  assign issue_o = instr_valid_i && ready_o;
  assign issue_dest_o = fields_i.rd;

  always_comb begin
    case (fields_i.opcode)
      OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_LOAD: begin
        issue_wb_o = 1'b1;
      end
      default: begin
        issue_wb_o = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Next state and control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = IDLE;
    alu_d     = ALU_CTRL_IDLE;
    lsu_d     = LSU_CTRL_IDLE;
    jmp_d     = JMP_IDLE;
    illegal_d = 1'b0;

    if (state_q == LSU_ADDR) begin
      // Issue cycle, address already sent to the ALU
      state_d      = LSU_ISSUE;
      lsu_d.valid  = 1'b1;
      lsu_d.store  = is_store;
      lsu_d.funct3 = fields_i.funct3;
      lsu_d.dest   = is_store ? '0 : fields_i.rd;
    end else if (stall_req) begin
      state_d = STALL;  // Controls stay idle
    end else if (instr_valid_i) begin
      case (fields_i.opcode)
        OPCODE_OP: begin
          alu_d.wb       = 1'b1;
          alu_d.sel      = alu_op_e'({fields_i.funct7[5], fields_i.funct3});
          alu_d.dest     = fields_i.rd;
          alu_d.rs1_addr = fields_i.rs1;
          alu_d.rs2_addr = fields_i.rs2;
        end
        OPCODE_OP_IMM: begin
          alu_d.wb       = 1'b1;
          // Bit 30 is part of the immediate unless this is a shift
          alu_d.sel      = is_shift ? alu_op_e'({fields_i.funct7[5], fields_i.funct3})
                                    : alu_op_e'({1'b0, fields_i.funct3});
          alu_d.dest     = fields_i.rd;
          alu_d.rs1_addr = fields_i.rs1;
          alu_d.use_imm  = 1'b1;
          alu_d.imm      = imm_i;
        end
        OPCODE_LUI, OPCODE_AUIPC: begin
          alu_d.wb      = 1'b1;
          alu_d.sel     = ALU_ADD;  // x0 plus imm, or PC plus imm
          alu_d.dest    = fields_i.rd;
          alu_d.use_imm = 1'b1;
          alu_d.use_pc  = (fields_i.opcode == OPCODE_AUIPC);
          alu_d.imm     = imm_i;
        end
        OPCODE_LOAD, OPCODE_STORE: begin
          // Address cycle, base plus offset
          state_d        = LSU_ADDR;
          alu_d.sel      = ALU_ADD;
          alu_d.rs1_addr = fields_i.rs1;
          alu_d.rs2_addr = is_store ? fields_i.rs2 : '0;  // Store data
          alu_d.use_imm  = 1'b1;
          alu_d.imm      = imm_i;
        end
        OPCODE_JAL: begin
          alu_d.wb      = 1'b1;  // Link write
          alu_d.sel     = ALU_ADD;
          alu_d.dest    = fields_i.rd;
          alu_d.use_imm = 1'b1;
          alu_d.use_pc  = 1'b1;
          alu_d.imm     = `DATA_WIDTH'(`LINK_OFFSET);
          jmp_d.valid   = 1'b1;
          jmp_d.addr    = jmp_target;
        end
        OPCODE_MISC_MEM: ;  // FENCE, nothing to order in this core
        default: begin
          illegal_d = 1'b1;
        end
      endcase
    end
  end

  // Registered controls, held for one cycle only
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q   <= IDLE;
      alu_o     <= ALU_CTRL_IDLE;
      lsu_o     <= LSU_CTRL_IDLE;
      jmp_o     <= JMP_IDLE;
      illegal_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      alu_o     <= alu_d;
      lsu_o     <= lsu_d;
      jmp_o     <= jmp_d;
      illegal_o <= illegal_d;
    end
  end

endmodule

/* hazard_unit.sv */
// Last issued destination register and read-after-write hazard detection
`include "decoder_macros.svh"

module hazard_unit (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  rv32i_isa_pkg::instr_fields_t fields_i,
  input  logic                         issue_i,
  input  logic                         issue_wb_i,
  input  logic [`REG_ADDR_WIDTH-1:0]   issue_dest_i,
  output logic                         hazard_o
);
  import rv32i_isa_pkg::*;

  logic [`REG_ADDR_WIDTH-1:0] last_dest_q;
  logic                       reads_rs1;
  logic                       reads_rs2;
  logic                       rs1_hit;
  logic                       rs2_hit;

  // Zero when the last issue wrote no register
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_dest_q <= '0;
    end else if (issue_i) begin
      last_dest_q <= issue_wb_i ? issue_dest_i : '0;
    end
  end

  // Source registers read by the presented instruction
  always_comb begin
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    case (fields_i.opcode)
      OPCODE_OP_IMM, OPCODE_LOAD: begin
        reads_rs1 = 1'b1;
      end
      OPCODE_OP, OPCODE_STORE: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      default: ;
    endcase
  end

  assign rs1_hit  = reads_rs1 && (fields_i.rs1 != '0) && (fields_i.rs1 == last_dest_q);
  assign rs2_hit  = reads_rs2 && (fields_i.rs2 != '0) && (fields_i.rs2 == last_dest_q);
  assign hazard_o = rs1_hit || rs2_hit;

endmodule

/* imm_gen.sv */
// Immediate extraction and sign extension for the I, I-shift, S, U and J formats
`include "decoder_macros.svh"

module imm_gen (
  input  rv32i_isa_pkg::instr_fields_t fields_i,
  output logic [`DATA_WIDTH-1:0]       imm_o
);
  import rv32i_isa_pkg::*;

  logic [`DATA_WIDTH-1:0] instr;
  logic [`DATA_WIDTH-1:0] imm_i_fmt;
  logic [`DATA_WIDTH-1:0] imm_shift;
  logic [`DATA_WIDTH-1:0] imm_s_fmt;
  logic [`DATA_WIDTH-1:0] imm_u_fmt;
  logic [`DATA_WIDTH-1:0] imm_j_fmt;
  logic                   is_shift;

  assign instr = fields_i;  // Back to raw bit positions

  ////////////////////////////////////////////////////////////
  // Per-format bit reordering
  ////////////////////////////////////////////////////////////

  assign imm_i_fmt = {{20{instr[31]}}, instr[31:20]};
  assign imm_shift = {27'b0, instr[24:20]};              // shamt, zero-extended
  assign imm_s_fmt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u_fmt = {instr[31:12], 12'b0};

  // J offset is in halfwords, bit 0 always zero
  assign imm_j_fmt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  assign is_shift = (fields_i.funct3 == `FUNCT3_SHIFT_LEFT) ||
                    (fields_i.funct3 == `FUNCT3_SHIFT_RIGHT);

  // Format select by opcode
  always_comb begin
    case (fields_i.opcode)
      OPCODE_LOAD: begin
        imm_o = imm_i_fmt;
      end
      OPCODE_OP_IMM: begin
        imm_o = is_shift ? imm_shift : imm_i_fmt;
      end
      OPCODE_STORE: begin
        imm_o = imm_s_fmt;
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        imm_o = imm_u_fmt;
      end
      OPCODE_JAL: begin
        imm_o = imm_j_fmt;
      end
      default: begin
        imm_o = '0;  // R-type and unsupported formats
      end
    endcase
  end

endmodule

/* decoder_pkg.sv */
// ALU operation enumeration and the ALU, LSU and jump control structs
`include "decoder_macros.svh"

package decoder_pkg;

  // Bit 30 of the instruction followed by funct3
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Control payloads towards execution
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                       wb;        // Write result to dest
    alu_op_e                    sel;
    logic [`REG_ADDR_WIDTH-1:0] dest;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic                       use_imm;   // Operand b from imm
    logic                       use_pc;    // Operand a from PC
    logic [`DATA_WIDTH-1:0]     imm;
  } alu_ctrl_t;

  typedef struct packed {
    logic                       valid;
    logic                       store;
    logic [2:0]                 funct3;    // Access width and sign
    logic [`REG_ADDR_WIDTH-1:0] dest;      // Load destination
  } lsu_ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic [`DATA_WIDTH-1:0] addr;
  } jmp_t;

  // Idle values, nothing requested
  localparam alu_ctrl_t ALU_CTRL_IDLE = '0;
  localparam lsu_ctrl_t LSU_CTRL_IDLE = '0;
  localparam jmp_t      JMP_IDLE      = '0;

endpackage

/* rv32i_isa_pkg.sv */
// RV32I opcode enumeration, funct3 shift codes and instruction field types
`include "decoder_macros.svh"

// funct3 codes of the shift-immediate forms
`define FUNCT3_SHIFT_LEFT  3'b001
`define FUNCT3_SHIFT_RIGHT 3'b101

package rv32i_isa_pkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_MISC_MEM = 7'b0001111,  // FENCE
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_OP       = 7'b0110011,
    OPCODE_LUI      = 7'b0110111,
    OPCODE_BRANCH   = 7'b1100011,  // Not supported, decodes as illegal
    OPCODE_JALR     = 7'b1100111,  // Not supported, decodes as illegal
    OPCODE_JAL      = 7'b1101111,
    OPCODE_SYSTEM   = 7'b1110011   // Not supported, decodes as illegal
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Field types
  ////////////////////////////////////////////////////////////

  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  // R-type view of the word, MSB first as in the instruction
  typedef struct packed {
    funct7_t   funct7;  // Bit 5 is instruction bit 30
    reg_addr_t rs2;
    reg_addr_t rs1;
    funct3_t   funct3;
    reg_addr_t rd;
    opcode_e   opcode;
  } instr_fields_t;

endpackage

/* decoder_macros.svh */
// Decoder data, register and ALU widths plus the link offset constant
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

// Data and address width
`define DATA_WIDTH 32

// Register index width, x0 to x31
`define REG_ADDR_WIDTH 5

// ALU select, bit 30 of the instruction on top of funct3
`define ALU_OP_WIDTH 4

////////////////////////////////////////////////////////////
// Fixed constants
////////////////////////////////////////////////////////////

`define LINK_OFFSET 4  // Return address is PC plus one instruction

`endif
